/* logic/cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F
    } opcode_e;

    // function field of R-type words
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_LOAD,
        DBG_RUN,
        DBG_DRAIN
    } dbg_state_e;

    localparam logic [31:0] HALT_WORD  = {OP_HALT, 26'd0};
    localparam int          PIPE_DEPTH = 4;   // fetch to write-back

endpackage

/* logic/instr_loader.sv */
`timescale 1ns/1ps

module instr_loader #(
    parameter int NB_DATA = 32,
    parameter int IMEM_AW = 6
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic [7:0]         rx_byte_i,
    input  logic               rx_valid_i,
    input  logic               rx_last_i,
    output logic               imem_we_o,
    output logic [IMEM_AW-1:0] imem_waddr_o,
    output logic [NB_DATA-1:0] imem_wdata_o,
    output logic               first_byte_o,
    output logic               finish_rcv_o
);

    localparam int N_BYTES = NB_DATA / 8;
    localparam int NB_CNT  = $clog2(N_BYTES);

    logic [NB_CNT-1:0]  byte_cnt;
    logic [NB_DATA-1:0] shift_q;
    logic [IMEM_AW:0]   addr_q;       // spare bit catches overflow
    logic               started_q;
    logic               loaded_q;
    logic               word_end;
    logic [NB_DATA-1:0] packed_word;

    assign word_end = rx_valid_i && (byte_cnt == NB_CNT'(N_BYTES - 1) || rx_last_i);

    // msb first and a short last word keeps its bytes on top
    assign packed_word = {shift_q[NB_DATA-9:0], rx_byte_i} << (8 * (N_BYTES - 1 - byte_cnt));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            byte_cnt     <= '0;
            addr_q       <= '0;
            started_q    <= 1'b0;
            loaded_q     <= 1'b0;
            imem_we_o    <= 1'b0;
            first_byte_o <= 1'b0;
            finish_rcv_o <= 1'b0;
        end else begin
            imem_we_o    <= word_end;
            first_byte_o <= rx_valid_i && !started_q;
            finish_rcv_o <= rx_valid_i && rx_last_i;   // same cycle as the last write
            if (rx_valid_i) begin
                started_q <= 1'b1;
            end
            if (rx_valid_i && rx_last_i) begin
                loaded_q <= 1'b1;
            end
            if (word_end) begin
                byte_cnt <= '0;
                addr_q   <= addr_q + 1'b1;
            end else if (rx_valid_i) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_valid_i) begin
            shift_q <= {shift_q[NB_DATA-9:0], rx_byte_i};
        end
        if (word_end) begin
            imem_wdata_o <= packed_word;
            imem_waddr_o <= addr_q[IMEM_AW-1:0];
        end
    end

    // program has to fit in the instruction memory
    a_addr_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        word_end |-> addr_q < (IMEM_AW + 1)'(2 ** IMEM_AW));

    // host stays quiet once the program runs
    a_no_rx_after_last: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        loaded_q |-> !rx_valid_i);

endmodule

/* logic/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic first_byte_i,
    input  logic finish_rcv_i,
    input  logic halt_fetched_i,
    output logic en_pipeline_o,
    output logic done_o
);

    localparam int NB_CNT = $clog2(cpu_pkg::PIPE_DEPTH);

    cpu_pkg::dbg_state_e state_q;
    logic [NB_CNT-1:0]   drain_cnt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= cpu_pkg::DBG_IDLE;
            drain_cnt     <= '0;
            en_pipeline_o <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            case (state_q)
                cpu_pkg::DBG_IDLE: begin
                    if (first_byte_i) begin
                        state_q <= cpu_pkg::DBG_LOAD;
                    end
                end
                cpu_pkg::DBG_LOAD: begin
                    if (finish_rcv_i) begin
                        state_q       <= cpu_pkg::DBG_RUN;
                        en_pipeline_o <= 1'b1;
                    end
                end
                cpu_pkg::DBG_RUN: begin
                    if (halt_fetched_i) begin
                        state_q   <= cpu_pkg::DBG_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                cpu_pkg::DBG_DRAIN: begin
                    // let the last real instructions reach write-back
                    if (drain_cnt == NB_CNT'(cpu_pkg::PIPE_DEPTH - 1)) begin
                        state_q       <= cpu_pkg::DBG_IDLE;
                        en_pipeline_o <= 1'b0;
                        done_o        <= 1'b1;   // sticky
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state_q <= cpu_pkg::DBG_IDLE;
            endcase
        end
    end

    a_en_only_running: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        en_pipeline_o |-> state_q inside {cpu_pkg::DBG_RUN, cpu_pkg::DBG_DRAIN});

    // halt seen in fetch ends the run after a fixed drain
    a_halt_to_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        halt_fetched_i && state_q == cpu_pkg::DBG_RUN |-> ##(cpu_pkg::PIPE_DEPTH + 1) done_o);

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter int NB_DATA = 32,
    parameter int IMEM_AW = 6
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               en_pipeline_i,
    input  logic               imem_we_i,
    input  logic [IMEM_AW-1:0] imem_waddr_i,
    input  logic [NB_DATA-1:0] imem_wdata_i,
    output logic [NB_DATA-1:0] instr_o,
    output logic               valid_o,
    output logic               halt_fetched_o
);

    logic [NB_DATA-1:0] imem [2 ** IMEM_AW];
    logic [IMEM_AW-1:0] pc_q;
    logic               halted_q;
    logic [NB_DATA-1:0] fetch_word;
    logic               is_halt;

    assign fetch_word = imem[pc_q];
    assign is_halt    = (fetch_word == NB_DATA'(cpu_pkg::HALT_WORD));

    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_waddr_i] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q           <= '0;
            halted_q       <= 1'b0;
            valid_o        <= 1'b0;
            halt_fetched_o <= 1'b0;
        end else begin
            halt_fetched_o <= 1'b0;
            if (en_pipeline_i) begin
                if (halted_q) begin
                    valid_o <= 1'b0;   // bubbles until drained
                end else begin
                    valid_o        <= !is_halt;
                    halt_fetched_o <= is_halt;
                    if (is_halt) begin
                        halted_q <= 1'b1;   // pc stays on the halt
                    end else begin
                        pc_q <= pc_q + 1'b1;
                    end
                end
            end
        end
    end

    // IF/ID
    always_ff @(posedge clk_i) begin
        if (en_pipeline_i && !halted_q) begin
            instr_o <= fetch_word;
        end
    end

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ps

module decode_top #(
    parameter int NB_DATA    = 32,
    parameter int N_REGISTER = 32
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          en_pipeline_i,
    input  logic [NB_DATA-1:0]            instr_i,
    input  logic                          valid_i,
    input  logic                          wb_reg_write_i,
    input  logic [$clog2(N_REGISTER)-1:0] wb_reg_i,
    input  logic [NB_DATA-1:0]            wb_data_i,
    output logic [NB_DATA-1:0]            data_ra_o,
    output logic [NB_DATA-1:0]            data_rb_o,
    output logic [NB_DATA-1:0]            imm_o,
    output cpu_pkg::alu_op_e              alu_op_o,
    output logic                          alu_src_imm_o,
    output logic [$clog2(N_REGISTER)-1:0] dest_reg_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          reg_write_o,
    output logic                          valid_o
);

    localparam int NB_REG = $clog2(N_REGISTER);

    logic [NB_DATA-1:0] regs [N_REGISTER];
    cpu_pkg::opcode_e   opcode;
    cpu_pkg::funct_e    funct;
    cpu_pkg::alu_op_e   alu_op;
    logic [NB_REG-1:0]  rs;
    logic [NB_REG-1:0]  rt;
    logic [NB_REG-1:0]  rd;
    logic [NB_REG-1:0]  dest;
    logic [15:0]        imm16;
    logic [NB_DATA-1:0] imm_ext;
    logic [NB_DATA-1:0] rd_a;
    logic [NB_DATA-1:0] rd_b;
    logic               alu_src_imm;
    logic               zero_ext;
    logic               use_rd;
    logic               mem_read;
    logic               mem_write;
    logic               reg_write;

    assign opcode = cpu_pkg::opcode_e'(instr_i[31:26]);
    assign funct  = cpu_pkg::funct_e'(instr_i[5:0]);
    assign rs     = NB_REG'(instr_i[25:21]);
    assign rt     = NB_REG'(instr_i[20:16]);
    assign rd     = NB_REG'(instr_i[15:11]);
    assign imm16  = instr_i[15:0];

    always_comb begin
        alu_op      = cpu_pkg::ALU_ADD;
        alu_src_imm = 1'b1;
        zero_ext    = 1'b0;
        use_rd      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                alu_src_imm = 1'b0;
                use_rd      = 1'b1;
                reg_write   = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: alu_op = cpu_pkg::ALU_SLT;
                    default:         reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDI: reg_write = 1'b1;
            cpu_pkg::OP_ORI: begin
                alu_op    = cpu_pkg::ALU_OR;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                alu_op    = cpu_pkg::ALU_LUI;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_SW: mem_write = 1'b1;
            default:        reg_write = 1'b0;   // halt and unknown words
        endcase
    end

    assign dest    = use_rd ? rd : rt;
    assign imm_ext = zero_ext ? {{(NB_DATA - 16){1'b0}}, imm16}
                              : {{(NB_DATA - 16){imm16[15]}}, imm16};

    // write-through read with r0 hardwired to zero
    function automatic logic [NB_DATA-1:0] read_reg(input logic [NB_REG-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_reg_write_i && wb_reg_i == idx) begin
            return wb_data_i;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_a = read_reg(rs);
        rd_b = read_reg(rt);
    end

    always_ff @(posedge clk_i) begin
        if (wb_reg_write_i && wb_reg_i != '0) begin
            regs[wb_reg_i] <= wb_data_i;
        end
    end

    // ID/EX
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            reg_write_o <= 1'b0;
        end else if (en_pipeline_i) begin
            valid_o     <= valid_i;
            mem_read_o  <= mem_read;
            mem_write_o <= mem_write;
            reg_write_o <= reg_write && dest != '0;   // r0 target gives no write-back
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_pipeline_i) begin
            data_ra_o     <= rd_a;
            data_rb_o     <= rd_b;
            imm_o         <= imm_ext;
            alu_op_o      <= alu_op;
            alu_src_imm_o <= alu_src_imm;
            dest_reg_o    <= dest;
        end
    end

endmodule

/* logic/execute_top.sv */
`timescale 1ns/1ps

module execute_top #(
    parameter int NB_DATA    = 32,
    parameter int N_REGISTER = 32
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          en_pipeline_i,
    input  logic [NB_DATA-1:0]            data_ra_i,
    input  logic [NB_DATA-1:0]            data_rb_i,
    input  logic [NB_DATA-1:0]            imm_i,
    input  cpu_pkg::alu_op_e              alu_op_i,
    input  logic                          alu_src_imm_i,
    input  logic [$clog2(N_REGISTER)-1:0] dest_reg_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  logic                          reg_write_i,
    input  logic                          valid_i,
    output logic [NB_DATA-1:0]            alu_result_o,
    output logic [NB_DATA-1:0]            store_data_o,
    output logic [$clog2(N_REGISTER)-1:0] dest_reg_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          reg_write_o,
    output logic                          valid_o
);

    logic [NB_DATA-1:0] op_b;
    logic [NB_DATA-1:0] result;

    assign op_b = alu_src_imm_i ? imm_i : data_rb_i;

    always_comb begin
        case (alu_op_i)
            cpu_pkg::ALU_ADD: result = data_ra_i + op_b;
            cpu_pkg::ALU_SUB: result = data_ra_i - op_b;
            cpu_pkg::ALU_AND: result = data_ra_i & op_b;
            cpu_pkg::ALU_OR:  result = data_ra_i | op_b;
            cpu_pkg::ALU_SLT: result = NB_DATA'($signed(data_ra_i) < $signed(op_b));
            cpu_pkg::ALU_LUI: result = op_b << 16;   // imm to the upper half
            default:          result = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            reg_write_o <= 1'b0;
        end else if (en_pipeline_i) begin
            valid_o     <= valid_i;
            mem_read_o  <= mem_read_i;
            mem_write_o <= mem_write_i;
            reg_write_o <= reg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_pipeline_i) begin
            alu_result_o <= result;
            store_data_o <= data_rb_i;
            dest_reg_o   <= dest_reg_i;
        end
    end

endmodule

/* logic/mem_top.sv */
`timescale 1ns/1ps

module mem_top #(
    parameter int NB_DATA    = 32,
    parameter int DMEM_AW    = 6,
    parameter int N_REGISTER = 32
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          en_pipeline_i,
    input  logic [NB_DATA-1:0]            alu_result_i,
    input  logic [NB_DATA-1:0]            store_data_i,
    input  logic [$clog2(N_REGISTER)-1:0] dest_reg_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  logic                          reg_write_i,
    input  logic                          valid_i,
    output logic                          wb_reg_write_o,
    output logic [$clog2(N_REGISTER)-1:0] wb_reg_o,
    output logic [NB_DATA-1:0]            wb_data_o
);

    logic [NB_DATA-1:0] dmem [2 ** DMEM_AW];
    logic [DMEM_AW-1:0] daddr;
    logic [NB_DATA-1:0] load_data;

    assign daddr     = alu_result_i[DMEM_AW+1:2];   // word index, byte offset dropped
    assign load_data = dmem[daddr];

    always_ff @(posedge clk_i) begin
        if (en_pipeline_i && valid_i && mem_write_i) begin
            dmem[daddr] <= store_data_i;
        end
    end

    // MEM/WB
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_reg_write_o <= 1'b0;
        end else if (en_pipeline_i) begin
            wb_reg_write_o <= valid_i && reg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_pipeline_i) begin
            wb_reg_o  <= dest_reg_i;
            wb_data_o <= mem_read_i ? load_data : alu_result_i;
        end
    end

    // word accesses only, a byte offset would alias onto the word
    a_word_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && (mem_read_i || mem_write_i) |-> alu_result_i[1:0] == 2'b00);

endmodule

/* logic/pipeline.sv */
`timescale 1ns/1ps

module pipeline #(
    parameter int NB_DATA    = 32,
    parameter int IMEM_AW    = 6,
    parameter int DMEM_AW    = 6,
    parameter int N_REGISTER = 32
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [7:0]                    rx_byte_i,
    input  logic                          rx_valid_i,
    input  logic                          rx_last_i,
    output logic                          wb_valid_o,
    output logic [$clog2(N_REGISTER)-1:0] wb_reg_o,
    output logic [NB_DATA-1:0]            wb_data_o,
    output logic                          done_o
);

    localparam int NB_REG = $clog2(N_REGISTER);

    logic               imem_we;
    logic [IMEM_AW-1:0] imem_waddr;
    logic [NB_DATA-1:0] imem_wdata;
    logic               first_byte;
    logic               finish_rcv;
    logic               en_pipeline;
    logic               halt_fetched;

    // fetch -> decode
    logic [NB_DATA-1:0] instr_fd;
    logic               valid_fd;

    // decode -> execute
    logic [NB_DATA-1:0] data_ra_de;
    logic [NB_DATA-1:0] data_rb_de;
    logic [NB_DATA-1:0] imm_de;
    cpu_pkg::alu_op_e   alu_op_de;
    logic               alu_src_imm_de;
    logic [NB_REG-1:0]  dest_reg_de;
    logic               mem_read_de;
    logic               mem_write_de;
    logic               reg_write_de;
    logic               valid_de;

    // execute -> mem
    logic [NB_DATA-1:0] alu_result_em;
    logic [NB_DATA-1:0] store_data_em;
    logic [NB_REG-1:0]  dest_reg_em;
    logic               mem_read_em;
    logic               mem_write_em;
    logic               reg_write_em;
    logic               valid_em;

    instr_loader #(
        .NB_DATA(NB_DATA),
        .IMEM_AW(IMEM_AW)
    ) u_instr_loader (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rx_byte_i    (rx_byte_i),
        .rx_valid_i   (rx_valid_i),
        .rx_last_i    (rx_last_i),
        .imem_we_o    (imem_we),
        .imem_waddr_o (imem_waddr),
        .imem_wdata_o (imem_wdata),
        .first_byte_o (first_byte),
        .finish_rcv_o (finish_rcv)
    );

    debug_unit u_debug_unit (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .first_byte_i   (first_byte),
        .finish_rcv_i   (finish_rcv),
        .halt_fetched_i (halt_fetched),
        .en_pipeline_o  (en_pipeline),
        .done_o         (done_o)
    );

    fetch_top #(
        .NB_DATA(NB_DATA),
        .IMEM_AW(IMEM_AW)
    ) u_fetch_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_pipeline_i  (en_pipeline),
        .imem_we_i      (imem_we),
        .imem_waddr_i   (imem_waddr),
        .imem_wdata_i   (imem_wdata),
        .instr_o        (instr_fd),
        .valid_o        (valid_fd),
        .halt_fetched_o (halt_fetched)
    );

    decode_top #(
        .NB_DATA   (NB_DATA),
        .N_REGISTER(N_REGISTER)
    ) u_decode_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_pipeline_i  (en_pipeline),
        .instr_i        (instr_fd),
        .valid_i        (valid_fd),
        .wb_reg_write_i (wb_valid_o),   // write-back loops from the top ports
        .wb_reg_i       (wb_reg_o),
        .wb_data_i      (wb_data_o),
        .data_ra_o      (data_ra_de),
        .data_rb_o      (data_rb_de),
        .imm_o          (imm_de),
        .alu_op_o       (alu_op_de),
        .alu_src_imm_o  (alu_src_imm_de),
        .dest_reg_o     (dest_reg_de),
        .mem_read_o     (mem_read_de),
        .mem_write_o    (mem_write_de),
        .reg_write_o    (reg_write_de),
        .valid_o        (valid_de)
    );

    execute_top #(
        .NB_DATA   (NB_DATA),
        .N_REGISTER(N_REGISTER)
    ) u_execute_top (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .en_pipeline_i (en_pipeline),
        .data_ra_i     (data_ra_de),
        .data_rb_i     (data_rb_de),
        .imm_i         (imm_de),
        .alu_op_i      (alu_op_de),
        .alu_src_imm_i (alu_src_imm_de),
        .dest_reg_i    (dest_reg_de),
        .mem_read_i    (mem_read_de),
        .mem_write_i   (mem_write_de),
        .reg_write_i   (reg_write_de),
        .valid_i       (valid_de),
        .alu_result_o  (alu_result_em),
        .store_data_o  (store_data_em),
        .dest_reg_o    (dest_reg_em),
        .mem_read_o    (mem_read_em),
        .mem_write_o   (mem_write_em),
        .reg_write_o   (reg_write_em),
        .valid_o       (valid_em)
    );

    mem_top #(
        .NB_DATA   (NB_DATA),
        .DMEM_AW   (DMEM_AW),
        .N_REGISTER(N_REGISTER)
    ) u_mem_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_pipeline_i  (en_pipeline),
        .alu_result_i   (alu_result_em),
        .store_data_i   (store_data_em),
        .dest_reg_i     (dest_reg_em),
        .mem_read_i     (mem_read_em),
        .mem_write_i    (mem_write_em),
        .reg_write_i    (reg_write_em),
        .valid_i        (valid_em),
        .wb_reg_write_o (wb_valid_o),
        .wb_reg_o       (wb_reg_o),
        .wb_data_o      (wb_data_o)
    );

endmodule

/* testbench/pipeline_checker.sv */
`timescale 1ns/1ps

module pipeline_checker #(
    parameter int NB_DATA = 32,
    parameter int NB_REG  = 5
) (
    input logic               clk_i,
    input logic               arst_n_i,
    input logic               rx_valid_i,
    input logic               rx_last_i,
    input logic               wb_valid_i,
    input logic [NB_REG-1:0]  wb_reg_i,
    input logic [NB_DATA-1:0] wb_data_i,
    input logic               done_i
);

    string              exp_name [$];
    logic [NB_REG-1:0]  exp_reg  [$];
    logic [NB_DATA-1:0] exp_val  [$];
    int                 next_idx = 0;
    int                 n_pass   = 0;
    int                 n_fail   = 0;
    logic               loaded   = 1'b0;

    task automatic add_expect(input string name, input logic [NB_REG-1:0] dest,
                              input logic [NB_DATA-1:0] value);
        exp_name.push_back(name);
        exp_reg.push_back(dest);
        exp_val.push_back(value);
    endtask

    // one write-back event against the next writing row
    task automatic check_write_back();
        if (done_i) begin
            $display("write-back to r%0d arrived after done_o rose", wb_reg_i);
            n_fail++;
        end else if (!loaded) begin
            $display("write-back to r%0d arrived before the program was loaded", wb_reg_i);
            n_fail++;
        end else if (next_idx >= exp_name.size()) begin
            $display("unexpected write-back r%0d = 0x%08h after the last test",
                     wb_reg_i, wb_data_i);
            n_fail++;
        end else begin
            if (wb_reg_i == exp_reg[next_idx] && wb_data_i == exp_val[next_idx]) begin
                $display("pass %s: r%0d = 0x%08h", exp_name[next_idx], wb_reg_i, wb_data_i);
                n_pass++;
            end else begin
                $display("Fail %s: expected r%0d = 0x%08h, actual r%0d = 0x%08h",
                         exp_name[next_idx], exp_reg[next_idx], exp_val[next_idx],
                         wb_reg_i, wb_data_i);
                n_fail++;
            end
            next_idx++;
        end
    endtask

    // rows that never saw their write-back
    task automatic finish_checks();
        while (next_idx < exp_name.size()) begin
            $display("%s: no write-back arrived for this test", exp_name[next_idx]);
            n_fail++;
            next_idx++;
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (rx_valid_i && rx_last_i) begin
                loaded = 1'b1;
            end
            if (wb_valid_i) begin
                check_write_back();
            end
        end
    end

endmodule

/* testbench/tb_pipeline.sv */
`timescale 1ns/1ps

module tb_pipeline;

    localparam int NB_DATA    = 32;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 6;
    localparam int N_REGISTER = 32;
    localparam int NB_REG     = $clog2(N_REGISTER);
    localparam int MAX_ROWS   = 2 ** IMEM_AW;

    logic               clock;
    logic               arst_n;
    logic [7:0]         rx_byte;
    logic               rx_valid;
    logic               rx_last;
    logic               wb_valid;
    logic [NB_REG-1:0]  wb_reg;
    logic [NB_DATA-1:0] wb_data;
    logic               done;

    logic [NB_DATA-1:0] prog_word  [MAX_ROWS];
    string              prog_name  [MAX_ROWS];
    logic               prog_write [MAX_ROWS];
    logic [NB_REG-1:0]  prog_reg   [MAX_ROWS];
    logic [NB_DATA-1:0] prog_val   [MAX_ROWS];
    int                 n_rows;
    int                 cycle_cnt;
    int                 cycle_limit;
    logic               timed_out;

    pipeline #(
        .NB_DATA   (NB_DATA),
        .IMEM_AW   (IMEM_AW),
        .DMEM_AW   (DMEM_AW),
        .N_REGISTER(N_REGISTER)
    ) dut (
        .clk_i      (clock),
        .arst_n_i   (arst_n),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .rx_last_i  (rx_last),
        .wb_valid_o (wb_valid),
        .wb_reg_o   (wb_reg),
        .wb_data_o  (wb_data),
        .done_o     (done)
    );

    pipeline_checker #(
        .NB_DATA(NB_DATA),
        .NB_REG (NB_REG)
    ) wb_check (
        .clk_i      (clock),
        .arst_n_i   (arst_n),
        .rx_valid_i (rx_valid),
        .rx_last_i  (rx_last),
        .wb_valid_i (wb_valid),
        .wb_reg_i   (wb_reg),
        .wb_data_i  (wb_data),
        .done_i     (done)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // add rd, rs, rt
    function automatic logic [31:0] encode_rtype(input cpu_pkg::funct_e fn, input int rd,
                                                 input int rs, input int rt);
        return {cpu_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    // op rt, rs, imm
    function automatic logic [31:0] encode_itype(input cpu_pkg::opcode_e op, input int rt,
                                                 input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic add_row(input logic [31:0] word, input string name, input logic writes,
                           input int dest, input logic [31:0] value);
        prog_word[n_rows]  = word;
        prog_name[n_rows]  = name;
        prog_write[n_rows] = writes;
        prog_reg[n_rows]   = NB_REG'(dest);
        prog_val[n_rows]   = value;
        n_rows++;
    endtask

    task automatic build_program();
        logic [31:0] nop;
        nop = encode_rtype(cpu_pkg::FN_ADD, 0, 0, 0);   // add r0, r0, r0
        n_rows = 0;
        add_row(encode_itype(cpu_pkg::OP_ADDI, 1, 0, 100), "addi_pos", 1, 1, 32'h0000_0064);
        add_row(encode_itype(cpu_pkg::OP_ADDI, 2, 0, -3), "addi_neg", 1, 2, 32'hFFFF_FFFD);
        add_row(encode_itype(cpu_pkg::OP_ORI, 3, 0, 16'h8001), "ori_zext", 1, 3, 32'h0000_8001);
        add_row(encode_itype(cpu_pkg::OP_LUI, 4, 0, 16'h1234), "lui", 1, 4, 32'h1234_0000);
        add_row(encode_itype(cpu_pkg::OP_ADDI, 5, 0, 16'h7FFF), "addi_max", 1, 5, 32'h0000_7FFF);
        add_row(encode_itype(cpu_pkg::OP_ADDI, 6, 0, 16'h8000), "addi_sext", 1, 6, 32'hFFFF_8000);
        add_row(encode_rtype(cpu_pkg::FN_ADD, 7, 1, 2), "add", 1, 7, 32'h0000_0061);
        add_row(encode_rtype(cpu_pkg::FN_SUB, 8, 1, 2), "sub", 1, 8, 32'h0000_0067);
        add_row(encode_rtype(cpu_pkg::FN_AND, 10, 3, 6), "and", 1, 10, 32'h0000_8000);
        add_row(encode_rtype(cpu_pkg::FN_OR, 11, 4, 5), "or", 1, 11, 32'h1234_7FFF);
        add_row(encode_rtype(cpu_pkg::FN_SLT, 12, 2, 1), "slt_neg_pos", 1, 12, 32'h1);
        add_row(encode_rtype(cpu_pkg::FN_SLT, 13, 1, 2), "slt_pos_neg", 1, 13, 32'h0);
        add_row(encode_rtype(cpu_pkg::FN_SLT, 14, 6, 2), "slt_neg_neg", 1, 14, 32'h1);
        add_row(encode_itype(cpu_pkg::OP_ORI, 15, 4, 16'h00FF), "ori_reg", 1, 15, 32'h1234_00FF);
        add_row(encode_itype(cpu_pkg::OP_ADDI, 0, 0, 5), "addi_r0", 0, 0, 32'h0);
        add_row(nop, "nop", 0, 0, 32'h0);
        add_row(nop, "nop", 0, 0, 32'h0);
        add_row(encode_rtype(cpu_pkg::FN_ADD, 9, 0, 1), "r0_operand", 1, 9, 32'h0000_0064);
        add_row(encode_itype(cpu_pkg::OP_SW, 4, 0, 8), "sw_a", 0, 0, 32'h0);
        add_row(encode_itype(cpu_pkg::OP_SW, 11, 0, 12), "sw_b", 0, 0, 32'h0);
        add_row(encode_itype(cpu_pkg::OP_LW, 16, 0, 8), "lw_a", 1, 16, 32'h1234_0000);
        add_row(encode_itype(cpu_pkg::OP_LW, 17, 0, 12), "lw_b", 1, 17, 32'h1234_7FFF);
        add_row(encode_itype(cpu_pkg::OP_SW, 15, 1, -4), "sw_base", 0, 0, 32'h0);
        add_row(encode_itype(cpu_pkg::OP_LW, 18, 1, -4), "lw_base", 1, 18, 32'h1234_00FF);
        add_row(encode_rtype(cpu_pkg::FN_SUB, 19, 17, 16), "sub_loaded", 1, 19, 32'h0000_7FFF);
        add_row(cpu_pkg::HALT_WORD, "halt", 0, 0, 32'h0);
    endtask

    task automatic send_byte(input logic [7:0] value, input logic last);
        @(posedge clock);
        #1;
        rx_byte  = value;
        rx_valid = 1'b1;
        rx_last  = last;
    endtask

    // msb first with the last flag on the final halt byte
    task automatic load_program();
        for (int r = 0; r < n_rows; r++) begin
            for (int b = 3; b >= 0; b--) begin
                send_byte(prog_word[r][8*b +: 8], r == n_rows - 1 && b == 0);
            end
        end
        @(posedge clock);
        #1;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic wait_for_done(output logic expired);
        while (!done && cycle_cnt < cycle_limit) begin
            @(negedge clock);
        end
        expired = !done;
    endtask

    initial begin
        arst_n   = 1'b0;
        rx_byte  = 8'h00;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        build_program();
        cycle_limit = 2 * (4 * n_rows + n_rows + cpu_pkg::PIPE_DEPTH + 20);
        for (int r = 0; r < n_rows; r++) begin
            if (prog_write[r]) begin
                wb_check.add_expect(prog_name[r], prog_reg[r], prog_val[r]);
            end
        end
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;
        load_program();
        wait_for_done(timed_out);
        if (timed_out) begin
            $display("timeout: done_o never rose within %0d cycles", cycle_limit);
            $display("Regression failed");
        end else begin
            repeat (cpu_pkg::PIPE_DEPTH + 2) @(negedge clock);   // catch late write-backs
            wb_check.finish_checks();
            $display("tests: %0d passed, %0d failed", wb_check.n_pass, wb_check.n_fail);
            if (wb_check.n_fail == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
        end
        $finish;
    end

endmodule

/* sim.f */
logic/cpu_pkg.sv
logic/instr_loader.sv
logic/debug_unit.sv
logic/fetch_top.sv
logic/decode_top.sv
logic/execute_top.sv
logic/mem_top.sv
logic/pipeline.sv
testbench/pipeline_checker.sv
testbench/tb_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_pipeline
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
